// File: rtl/vmem_config.svh
// fixed widths of the vector memory stage, included by the package, the RTL and the testbench.
`ifndef VMEM_CONFIG_SVH
`define VMEM_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths follow rv32, so none of them are module parameters.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// byte address width on the data port.
`define VMEM_ADDR_W 32

// one data word as moved on the data port.
`define VMEM_DATA_W 32

// element offset within the vector register group.
// five bits cover up to 32 elements.
`define VMEM_WOFF_W 5

`endif

// File: rtl/vmem_pkg.sv
// types of the vector memory stage, imported by every RTL block and by the testbench.
`include "vmem_config.svh"

package vmem_pkg;

  // element width as encoded in the load/store instruction.
  typedef enum logic [1:0] {
    WIDTH8,
    WIDTH16,
    WIDTH32
  } eew_t;

  // element width held in the vtype control register.
  // indexed access sizes its data by this one.
  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } sew_t;

  // how the two element addresses are formed.
  typedef enum logic [1:0] {
    MODE_UNIT,
    MODE_STRIDED,
    MODE_INDEXED
  } addr_mode_t;

  // access size on the data port, word is the zero code.
  typedef enum logic [1:0] {
    BSEL_WORD,
    BSEL_HALF,
    BSEL_BYTE
  } bytesel_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one command covering a pair of elements.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                     load_ena;
    logic                     store_ena;
    addr_mode_t               mode;
    eew_t                     eew;
    sew_t                     sew;
    logic                     segment_type;
    logic [`VMEM_ADDR_W-1:0]  base;
    logic [`VMEM_ADDR_W-1:0]  stride;
    logic [`VMEM_ADDR_W-1:0]  idx0;
    logic [`VMEM_ADDR_W-1:0]  idx1;
    logic [`VMEM_WOFF_W-1:0]  woffset;
    logic [`VMEM_DATA_W-1:0]  storedata0;
    logic [`VMEM_DATA_W-1:0]  storedata1;
  } vmem_cmd_t;

  // request on the single data port.
  typedef struct packed {
    logic [`VMEM_ADDR_W-1:0]  final_addr;
    logic [`VMEM_DATA_W-1:0]  final_storedata;
    logic                     ren;
    logic                     wen;
    bytesel_t                 byte_ena;
  } mem_req_t;

endpackage

// File: rtl/address_generator.sv
// combinational address generation for the two elements of one vector load or store command.
`timescale 1ns/10ps
`include "vmem_config.svh"

module address_generator (
  input  vmem_pkg::vmem_cmd_t      cmd,
  output logic [`VMEM_ADDR_W-1:0]  addr0,
  output logic [`VMEM_ADDR_W-1:0]  addr1
);

  import vmem_pkg::*;

  // log2 of the element size in bytes.
  logic [1:0]               size_shift;
  // element offsets widened to the address width.
  logic [`VMEM_ADDR_W-1:0]  off0;
  logic [`VMEM_ADDR_W-1:0]  off1;

  // one element address, shared by both elements.
  function automatic logic [`VMEM_ADDR_W-1:0] elem_addr(
    input addr_mode_t               mode,
    input logic [`VMEM_ADDR_W-1:0]  base,
    input logic [`VMEM_ADDR_W-1:0]  stride,
    input logic [`VMEM_ADDR_W-1:0]  offset,
    input logic [`VMEM_ADDR_W-1:0]  index,
    input logic [1:0]               shift
  );
    logic [`VMEM_ADDR_W-1:0] step;
    case (mode)
      // packed elements, step is offset times element size.
      MODE_UNIT:    step = offset << shift;
      // step is offset times the byte stride.
      MODE_STRIDED: step = offset * stride;
      // index register holds the byte offset directly.
      default:      step = index;
    endcase
    return base + step;
  endfunction

  // element size.
  // indexed access takes sew from the control register, the rest take eew.
  always_comb
  begin
    if (cmd.mode == MODE_INDEXED)
    begin
      case (cmd.sew)
        SEW8:    size_shift = 2'd0;
        SEW16:   size_shift = 2'd1;
        default: size_shift = 2'd2;
      endcase
    end
    else
    begin
      case (cmd.eew)
        WIDTH8:  size_shift = 2'd0;
        WIDTH16: size_shift = 2'd1;
        default: size_shift = 2'd2;
      endcase
    end
  end

  // second element sits one offset further.
  assign off0 = {{(`VMEM_ADDR_W-`VMEM_WOFF_W){1'b0}}, cmd.woffset};
  assign off1 = off0 + 1;

  assign addr0 = elem_addr(cmd.mode, cmd.base, cmd.stride, off0, cmd.idx0, size_shift);
  assign addr1 = elem_addr(cmd.mode, cmd.base, cmd.stride, off1, cmd.idx1, size_shift);

endmodule

// File: rtl/address_scheduler.sv
// fsm that orders the two element accesses on the data port and flags misaligned addresses.
`timescale 1ns/10ps
`include "vmem_config.svh"

module address_scheduler (
  input  logic                     CLK,
  input  logic                     nRST,
  input  vmem_pkg::vmem_cmd_t      cmd,
  input  logic [`VMEM_ADDR_W-1:0]  addr0,
  input  logic [`VMEM_ADDR_W-1:0]  addr1,
  input  logic                     dhit,
  input  logic                     returnex,
  output vmem_pkg::mem_req_t       mem,
  output logic                     busy,
  output logic                     exception,
  output logic                     arrived0,
  output logic                     arrived1
);

  import vmem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD0,
    LOAD1,
    STORE0,
    STORE1,
    EX
  } state_t;

  state_t    state;
  state_t    next_state;
  logic      daccess;
  logic      misalign0;
  logic      misalign1;
  bytesel_t  bsel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign daccess   = cmd.load_ena | cmd.store_ena;
  // only word-aligned addresses are legal outside segment access.
  assign misalign0 = daccess & (addr0[1:0] != 2'b00) & ~cmd.segment_type;
  assign misalign1 = daccess & (addr1[1:0] != 2'b00) & ~cmd.segment_type;

  // a load element is in when its read hits.
  assign arrived0  = (state == LOAD0) & dhit;
  assign arrived1  = (state == LOAD1) & dhit;

  // access size, sew for indexed access and eew otherwise.
  always_comb
  begin
    if (cmd.mode == MODE_INDEXED)
      bsel = (cmd.sew == SEW32) ? BSEL_WORD : (cmd.sew == SEW16) ? BSEL_HALF : BSEL_BYTE;
    else
      bsel = (cmd.eew == WIDTH32) ? BSEL_WORD : (cmd.eew == WIDTH16) ? BSEL_HALF : BSEL_BYTE;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        // misaligned first element never reaches memory.
        if (misalign0)          next_state = EX;
        else if (cmd.load_ena)  next_state = LOAD0;
        else if (cmd.store_ena) next_state = STORE0;
      end
      LOAD0:
      begin
        if (dhit)
          next_state = misalign1 ? EX : LOAD1;
      end
      STORE0:
      begin
        if (dhit)
          next_state = misalign1 ? EX : STORE1;
      end
      LOAD1, STORE1:
      begin
        if (dhit) next_state = IDLE;
      end
      // wait for the requester to take the exception.
      EX:
      begin
        if (returnex) next_state = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

  // port outputs by state.
  always_comb
  begin
    mem          = '0;
    mem.byte_ena = bsel;
    busy         = 1'b1;
    exception    = 1'b0;
    case (state)
      IDLE:   busy = daccess;
      LOAD0:
      begin
        mem.final_addr = addr0;
        mem.ren        = 1'b1;
      end
      LOAD1:
      begin
        mem.final_addr = addr1;
        mem.ren        = 1'b1;
        // busy drops in the cycle of the last hit.
        busy           = ~dhit;
      end
      STORE0:
      begin
        mem.final_addr      = addr0;
        mem.final_storedata = cmd.storedata0;
        mem.wen             = 1'b1;
      end
      STORE1:
      begin
        mem.final_addr      = addr1;
        mem.final_storedata = cmd.storedata1;
        mem.wen             = 1'b1;
        busy                = ~dhit;
      end
      EX:
      begin
        busy      = 1'b0;
        exception = 1'b1;
      end
      default: busy = 1'b0;
    endcase
  end

endmodule

// File: rtl/load_collector.sv
// captures the two loaded words and trims each to the element width.
`timescale 1ns/10ps
`include "vmem_config.svh"

module load_collector (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     arrived0,
  input  logic                     arrived1,
  input  vmem_pkg::bytesel_t       byte_ena,
  input  logic [`VMEM_DATA_W-1:0]  rdata,
  output logic [`VMEM_DATA_W-1:0]  load_data0,
  output logic [`VMEM_DATA_W-1:0]  load_data1,
  output logic                     load_done
);

  import vmem_pkg::*;

  // read word after trimming.
  logic [`VMEM_DATA_W-1:0] trimmed;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // width trim.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // elements sit in the low bytes of the word.
  // upper bits are zero-filled, no sign extension.
  always_comb
  begin
    case (byte_ena)
      BSEL_BYTE: trimmed = {{(`VMEM_DATA_W-8){1'b0}}, rdata[7:0]};
      BSEL_HALF: trimmed = {{(`VMEM_DATA_W-16){1'b0}}, rdata[15:0]};
      default:   trimmed = rdata;
    endcase
  end

  // element registers.
  // each loads only on its own arrival strobe.
  always_ff @(posedge CLK)
  begin
    if (arrived0)
      load_data0 <= trimmed;
    if (arrived1)
      load_data1 <= trimmed;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // completion strobe.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one cycle after the second element lands.
  // both data registers are stable by then.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      load_done <= 1'b0;
    else
      load_done <= arrived1;
  end

endmodule

// File: rtl/vmem_unit.sv
// top of the vector memory access stage, connecting address generation, scheduling and load capture.
`timescale 1ns/10ps
`include "vmem_config.svh"

module vmem_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  vmem_pkg::vmem_cmd_t      cmd,
  input  logic                     returnex,
  input  logic                     dhit,
  input  logic [`VMEM_DATA_W-1:0]  rdata,
  output vmem_pkg::mem_req_t       mem,
  output logic                     busy,
  output logic                     exception,
  output logic [`VMEM_DATA_W-1:0]  load_data0,
  output logic [`VMEM_DATA_W-1:0]  load_data1,
  output logic                     load_done
);

  // element addresses from the generator.
  logic [`VMEM_ADDR_W-1:0] addr0;
  logic [`VMEM_ADDR_W-1:0] addr1;
  // load hit strobes per element.
  logic                    arrived0;
  logic                    arrived1;

  // address calculation, purely combinational.
  address_generator u_agen (
    .cmd   (cmd),
    .addr0 (addr0),
    .addr1 (addr1)
  );

  // access ordering and the data port.
  address_scheduler u_sched (
    .CLK       (CLK),
    .nRST      (nRST),
    .cmd       (cmd),
    .addr0     (addr0),
    .addr1     (addr1),
    .dhit      (dhit),
    .returnex  (returnex),
    .mem       (mem),
    .busy      (busy),
    .exception (exception),
    .arrived0  (arrived0),
    .arrived1  (arrived1)
  );

  // load data capture, trimmed by the port access size.
  load_collector u_coll (
    .CLK        (CLK),
    .nRST       (nRST),
    .arrived0   (arrived0),
    .arrived1   (arrived1),
    .byte_ena   (mem.byte_ena),
    .rdata      (rdata),
    .load_data0 (load_data0),
    .load_data1 (load_data1),
    .load_done  (load_done)
  );

endmodule

// File: tb/vmem_checker.sv
// testbench monitor that watches the vector memory stage ports and compares them with expected values.
`timescale 1ns/10ps
`include "vmem_config.svh"

module vmem_checker (
  input  logic                     CLK,
  input  logic                     nRST,
  input  vmem_pkg::vmem_cmd_t      cmd,
  input  vmem_pkg::mem_req_t       mem,
  input  logic                     dhit,
  input  logic                     busy,
  input  logic                     exception,
  input  logic [`VMEM_DATA_W-1:0]  load_data0,
  input  logic [`VMEM_DATA_W-1:0]  load_data1,
  input  logic                     load_done,
  input  logic [`VMEM_ADDR_W-1:0]  exp_addr0,
  input  logic [`VMEM_ADDR_W-1:0]  exp_addr1,
  input  logic [1:0]               exp_ex,
  input  logic                     new_cmd,
  input  logic                     run_end,
  output int                       err_count,
  output int                       check_count
);

  import vmem_pkg::*;

  // expected memory contents, kept up to date from the command's store data.
  logic [`VMEM_DATA_W-1:0] shadow [0:1023];
  logic       active;
  logic       cur_load;
  logic [1:0] cur_ex;
  int         acc;
  logic       ex_seen;
  logic       done_seen;
  logic       final_hit;

  // initial word at word address a.
  function automatic logic [31:0] word_rule(input logic [31:0] a);
    return {a[15:0] ^ 16'hA5C3, a[15:0]};
  endfunction

  // access size follows sew for indexed commands, eew otherwise.
  // both width enums code 8, 16 and 32 bits as 0, 1 and 2.
  function automatic bytesel_t size_of(input vmem_cmd_t c);
    logic [1:0] code;
    if (c.mode == MODE_INDEXED)
      code = c.sew;
    else
      code = c.eew;
    case (code)
      2'd0:    return BSEL_BYTE;
      2'd1:    return BSEL_HALF;
      default: return BSEL_WORD;
    endcase
  endfunction

  function automatic logic [31:0] low_part(input logic [31:0] d, input bytesel_t b);
    if (b == BSEL_BYTE)
      return {24'd0, d[7:0]};
    if (b == BSEL_HALF)
      return {16'd0, d[15:0]};
    return d;
  endfunction

  // store replaces only the low bytes of the word.
  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                        input bytesel_t b);
    if (b == BSEL_BYTE)
      return {old[31:8], d[7:0]};
    if (b == BSEL_HALF)
      return {old[31:16], d[15:0]};
    return d;
  endfunction

  task automatic report(input string msg);
    err_count = err_count + 1;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
    check_count = check_count + 1;
    if (got !== want)
      report($sformatf("%s is %h, expected %h", what, got, want));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // end of command checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic close_command();
    if (active)
    begin
      check_count = check_count + 1;
      if (cur_ex != 2'd0 && !ex_seen)
        report("expected exception did not occur");
      if (cur_ex == 2'd0 && acc != 2)
        report($sformatf("command made %0d accesses, expected 2", acc));
      if (cur_ex == 2'd0 && cur_load && !done_seen)
        report("load_done never pulsed");
    end
    active = 1'b0;
  endtask

  // one hit on the data port.
  task automatic check_access();
    logic [31:0] want_addr;
    logic [31:0] sd;
    bytesel_t    b;
    b         = size_of(cmd);
    want_addr = (acc == 0) ? exp_addr0 : exp_addr1;
    sd        = (acc == 0) ? cmd.storedata0 : cmd.storedata1;
    compare(mem.final_addr, want_addr, $sformatf("address of element %0d", acc));
    compare({30'd0, mem.byte_ena}, {30'd0, b}, "byte_ena");
    // a load reads and a store writes.
    compare({30'd0, mem.ren, mem.wen}, {30'd0, cmd.load_ena, cmd.store_ena}, "ren/wen");
    if (cmd.store_ena)
    begin
      compare(low_part(mem.final_storedata, b), low_part(sd, b), "store data");
      shadow[want_addr[11:2]] = merge(shadow[want_addr[11:2]], sd, b);
    end
    acc = acc + 1;
  endtask

  task automatic check_exception();
    ex_seen     = 1'b1;
    check_count = check_count + 1;
    if (cur_ex == 2'd0)
      report("unexpected exception");
    else if (acc != int'(cur_ex) - 1)
      report($sformatf("exception after %0d accesses, expected %0d", acc, int'(cur_ex) - 1));
  endtask

  task automatic check_load();
    bytesel_t b;
    b         = size_of(cmd);
    done_seen = 1'b1;
    compare(load_data0, low_part(shadow[exp_addr0[11:2]], b), "load_data0");
    compare(load_data1, low_part(shadow[exp_addr1[11:2]], b), "load_data1");
  endtask

  initial
  begin
    err_count   = 0;
    check_count = 0;
    active      = 1'b0;
    acc         = 0;
    for (int i = 0; i < 1024; i++)
      shadow[i] = word_rule(i);
  end

  // outputs settle well before the falling edge.
  always @(negedge CLK)
  begin
    if (nRST)
    begin
      if (new_cmd || run_end)
        close_command();
      if (new_cmd)
      begin
        active    = 1'b1;
        cur_load  = cmd.load_ena;
        cur_ex    = exp_ex;
        acc       = 0;
        ex_seen   = 1'b0;
        done_seen = 1'b0;
      end
      final_hit = (acc == 1) && (mem.ren || mem.wen) && dhit;
      if ((mem.ren || mem.wen) && acc >= 2)
        report("memory request after the second element");
      else if ((mem.ren || mem.wen) && dhit)
        check_access();
      if (exception && !ex_seen)
        check_exception();
      if (load_done)
        check_load();
      // busy holds from the enable until the final hit.
      // with no enable present it stays low.
      if (cmd.load_ena || cmd.store_ena)
      begin
        check_count = check_count + 1;
        if (busy !== !(exception || final_hit))
          report($sformatf("busy is %b during command", busy));
      end
      else
      begin
        check_count = check_count + 1;
        if (busy !== 1'b0)
          report("busy is high with no enable present");
      end
    end
  end

endmodule

// File: tb/vmem_unit_tb.sv
// testbench top for the vector memory stage: clock, reset, command driver, memory model and verdict.
`timescale 1ns/10ps
`include "vmem_config.svh"

module vmem_unit_tb;

  import vmem_pkg::*;

  localparam int WORDS_PER_TEST = 10;
  localparam int MAX_TESTS      = 32;

  logic                     CLK;
  logic                     nRST;
  vmem_cmd_t                cmd;
  logic                     returnex;
  logic                     dhit = 1'b0;
  logic [`VMEM_DATA_W-1:0]  rdata = '0;
  mem_req_t                 mem;
  logic                     busy;
  logic                     exception;
  logic [`VMEM_DATA_W-1:0]  load_data0;
  logic [`VMEM_DATA_W-1:0]  load_data1;
  logic                     load_done;
  logic [`VMEM_ADDR_W-1:0]  exp_addr0;
  logic [`VMEM_ADDR_W-1:0]  exp_addr1;
  logic [1:0]               exp_ex;
  logic                     new_cmd;
  logic                     run_end;
  int                       err_count;
  int                       check_count;

  logic [31:0] tests [0:WORDS_PER_TEST*MAX_TESTS-1];
  logic [31:0] mem_words [0:1023];
  int          num_tests;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        pending = 1'b0;
  int          wait_left = 0;

  vmem_unit UUT (
    .CLK        (CLK),
    .nRST       (nRST),
    .cmd        (cmd),
    .returnex   (returnex),
    .dhit       (dhit),
    .rdata      (rdata),
    .mem        (mem),
    .busy       (busy),
    .exception  (exception),
    .load_data0 (load_data0),
    .load_data1 (load_data1),
    .load_done  (load_done)
  );

  vmem_checker u_checker (
    .CLK         (CLK),
    .nRST        (nRST),
    .cmd         (cmd),
    .mem         (mem),
    .dhit        (dhit),
    .busy        (busy),
    .exception   (exception),
    .load_data0  (load_data0),
    .load_data1  (load_data1),
    .load_done   (load_done),
    .exp_addr0   (exp_addr0),
    .exp_addr1   (exp_addr1),
    .exp_ex      (exp_ex),
    .new_cmd     (new_cmd),
    .run_end     (run_end),
    .err_count   (err_count),
    .check_count (check_count)
  );

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data memory model, answers after 0 to 3 wait cycles.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    for (int i = 0; i < 1024; i++)
      mem_words[i] = {i[15:0] ^ 16'hA5C3, i[15:0]};
  end

  always @(posedge CLK)
  begin
    #1;
    dhit = 1'b0;
    if (mem.ren || mem.wen)
    begin
      if (!pending)
      begin
        pending   = 1'b1;
        wait_left = $urandom % 4;
      end
      if (wait_left == 0)
      begin
        pending = 1'b0;
        dhit    = 1'b1;
        if (mem.ren)
          rdata = mem_words[mem.final_addr[11:2]];
        else if (mem.byte_ena == BSEL_BYTE)
          mem_words[mem.final_addr[11:2]][7:0] = mem.final_storedata[7:0];
        else if (mem.byte_ena == BSEL_HALF)
          mem_words[mem.final_addr[11:2]][15:0] = mem.final_storedata[15:0];
        else
          mem_words[mem.final_addr[11:2]] = mem.final_storedata;
      end
      else
        wait_left = wait_left - 1;
    end
  end

  // run limit scales with the number of commands.
  always @(posedge CLK)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // one command from the data file, held until busy is seen low.
  task automatic run_command(input int t);
    int          b;
    logic [31:0] ctrl;
    logic        saw_ex;
    b                = t * WORDS_PER_TEST;
    ctrl             = tests[b];
    cmd.load_ena     = (ctrl[31:28] == 4'd1);
    cmd.store_ena    = (ctrl[31:28] == 4'd2);
    cmd.mode         = addr_mode_t'(ctrl[25:24]);
    cmd.eew          = eew_t'(ctrl[21:20]);
    cmd.sew          = sew_t'(ctrl[17:16]);
    cmd.segment_type = ctrl[12];
    cmd.woffset      = ctrl[4:0];
    cmd.base         = tests[b+1];
    cmd.stride       = tests[b+2];
    cmd.idx0         = tests[b+3];
    cmd.idx1         = tests[b+4];
    cmd.storedata0   = tests[b+5];
    cmd.storedata1   = tests[b+6];
    exp_addr0        = tests[b+7];
    exp_addr1        = tests[b+8];
    exp_ex           = tests[b+9][1:0];
    new_cmd          = 1'b1;
    @(posedge CLK);
    #1 new_cmd = 1'b0;
    do
      @(negedge CLK);
    while (busy);
    saw_ex = exception;
    @(posedge CLK);
    #1;
    cmd.load_ena  = 1'b0;
    cmd.store_ena = 1'b0;
    if (saw_ex)
    begin
      returnex = 1'b1;
      @(posedge CLK);
      #1 returnex = 1'b0;
    end
    @(posedge CLK);
    #1;
  endtask

  initial
  begin
    void'($urandom(31));
    nRST      = 1'b0;
    cmd       = '0;
    returnex  = 1'b0;
    exp_addr0 = '0;
    exp_addr1 = '0;
    exp_ex    = 2'd0;
    new_cmd   = 1'b0;
    run_end   = 1'b0;
    for (int i = 0; i < WORDS_PER_TEST * MAX_TESTS; i++)
      tests[i] = '0;
    $readmemh("tb/vmem_tests.txt", tests);
    // a zero operation code ends the list.
    num_tests = 0;
    while (num_tests < MAX_TESTS && tests[num_tests * WORDS_PER_TEST][31:28] != 4'd0)
      num_tests = num_tests + 1;
    cycle_limit = 40 * num_tests + 20;
    repeat (2) @(posedge CLK);
    #1 nRST = 1'b1;
    @(posedge CLK);
    #1;
    for (int t = 0; t < num_tests; t++)
      run_command(t);
    run_end = 1'b1;
    @(posedge CLK);
    #1 run_end = 1'b0;
    @(posedge CLK);
    if (num_tests == 0)
      $display("no commands were found in the data file");
    $display("commands: %0d checks: %0d errors: %0d", num_tests, check_count, err_count);
    if (err_count == 0 && num_tests > 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: tb/vmem_tests.txt
// ctrl: op(1 load,2 store) mode eew sew segment 0 woffset | base stride idx0 idx1
// storedata0 storedata1 | expected addr0 addr1 exception(0 none,1 first,2 second)
10220002 00000100 00000000 00000000 00000000 00000000 00000000 00000108 0000010C 0
10110002 00000200 00000000 00000000 00000000 00000000 00000000 00000204 00000206 2
10001004 00000300 00000000 00000000 00000000 00000000 00000000 00000304 00000305 0
10111001 00000400 00000000 00000000 00000000 00000000 00000000 00000402 00000404 0
11220003 00000500 00000020 00000000 00000000 00000000 00000000 00000560 00000580 0
11110001 00000600 00000010 00000000 00000000 00000000 00000000 00000610 00000620 0
12200000 00000700 00000000 00000008 00000014 00000000 00000000 00000708 00000714 0
12010000 00000800 00000000 00000000 00000040 00000000 00000000 00000800 00000840 0
20220000 00000900 00000000 00000000 00000000 11223344 55667788 00000900 00000904 0
10220000 00000900 00000000 00000000 00000000 00000000 00000000 00000900 00000904 0
21110002 00000A00 00000008 00000000 00000000 DEADBEEF CAFEF00D 00000A10 00000A18 0
11220002 00000A00 00000008 00000000 00000000 00000000 00000000 00000A10 00000A18 0
22200000 00000B00 00000000 00000004 0000000C 000000AB 123456CD 00000B04 00000B0C 0
12020000 00000B00 00000000 00000004 0000000C 00000000 00000000 00000B04 00000B0C 0
12220000 00000C00 00000000 00000001 00000004 00000000 00000000 00000C01 00000C04 1
21220001 00000D00 00000006 00000000 00000000 00000000 00000000 00000D06 00000D0C 1
22220000 00000E00 00000000 00000000 00000002 76543210 89ABCDEF 00000E00 00000E02 2
20001001 00000F00 00000000 00000000 00000000 0000005A 000000A5 00000F01 00000F02 0
10001001 00000F00 00000000 00000000 00000000 00000000 00000000 00000F01 00000F02 0
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0

// File: vmem_unit.f
+incdir+rtl
rtl/vmem_pkg.sv
rtl/address_generator.sv
rtl/address_scheduler.sv
rtl/load_collector.sv
rtl/vmem_unit.sv
tb/vmem_checker.sv
tb/vmem_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the vector memory stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module vmem_unit_tb -f vmem_unit.f -o vmem_sim &&
./obj_dir/vmem_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "simulation passed" ||
{
  echo "simulation failed"
  exit 1
}
